// File: hdl/ex_pkg.sv
package ex_pkg;

    // datapath widths.
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;   // shift amount taken from operand two.

    // pc step for jal/jalr link values.
    localparam int LINK_OFFSET = 4;

    // immediate forms share the code of the register form via use_imm.
    typedef enum logic [4:0] {
        op_nop,
        op_add,
        op_sub,
        op_xor,
        op_or,
        op_and,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        // memory address generation.
        op_load,
        op_store,
        // conditional branches.
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_bltu,
        op_bgeu,
        // jumps and upper immediates.
        op_jal,
        op_jalr,
        op_lui,
        op_auipc
    } ex_opcode_e;

    // decoded operation as it enters the stage.
    typedef struct packed {
        ex_opcode_e            opcode;
        logic                  use_imm;   // operand two is imm.
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
    } ex_op_t;

    // registered result sent downstream.
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
        logic                  redirect;
        logic [XLEN-1:0]       target;   // zero unless redirect.
    } ex_res_t;

endpackage

// File: hdl/credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic
) (
    input  logic     i_clk,
    input  logic     reset_i,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        // wrap by hand so DEPTH need not be a power of two.
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // entry storage written on push.
    always_ff @(posedge i_clk) begin
        if (push_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge i_clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither.
            endcase
        end
    end

    // upstream credit keeps push from ever overrunning.
    assign data_o  = mem[rd_ptr];
    assign empty_o = (count == '0);

endmodule

// File: hdl/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::ex_op_t            op_i,
    output logic [ex_pkg::XLEN-1:0]   data_o
);
    import ex_pkg::*;

    logic [XLEN-1:0]    opa;
    logic [XLEN-1:0]    opb;
    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;
    logic [XLEN-1:0]    addr;

    assign opa   = op_i.rs1_data;
    assign opb   = op_i.use_imm ? op_i.imm : op_i.rs2_data;
    assign shamt = opb[SHAMT_W-1:0];   // low bits only.

    assign lt_signed   = $signed(opa) < $signed(opb);
    assign lt_unsigned = opa < opb;

    // loads and stores always use the immediate offset.
    assign addr = op_i.rs1_data + op_i.imm;

    always_comb begin
        case (op_i.opcode)
            op_add: begin
                data_o = opa + opb;
            end
            op_sub: begin
                data_o = opa - opb;
            end
            op_xor: begin
                data_o = opa ^ opb;
            end
            op_or: begin
                data_o = opa | opb;
            end
            op_and: begin
                data_o = opa & opb;
            end
            op_sll: begin
                data_o = opa << shamt;
            end
            op_srl: begin
                data_o = opa >> shamt;
            end
            op_sra: begin
                data_o = $unsigned($signed(opa) >>> shamt);
            end
            op_slt: begin
                data_o = {{(XLEN-1){1'b0}}, lt_signed};
            end
            op_sltu: begin
                data_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            op_load, op_store: begin
                data_o = addr;
            end
            op_lui: begin
                data_o = op_i.imm;   // already shifted by decode.
            end
            op_auipc: begin
                data_o = op_i.pc + op_i.imm;
            end
            default: begin
                // nop and control flow land here.
                data_o = '0;
            end
        endcase
    end

endmodule

// File: hdl/ex_branch.sv
`timescale 1ns/1ps

module ex_branch (
    input  ex_pkg::ex_op_t            op_i,
    output logic                      ctrl_o,
    output logic                      redirect_o,
    output logic [ex_pkg::XLEN-1:0]   data_o,
    output logic [ex_pkg::XLEN-1:0]   target_o
);
    import ex_pkg::*;

    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] pc_rel;
    logic [XLEN-1:0] reg_rel;
    logic [XLEN-1:0] link;
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic            take;

    assign rs1 = op_i.rs1_data;
    assign rs2 = op_i.rs2_data;

    assign eq   = (rs1 == rs2);
    assign lt_s = $signed(rs1) < $signed(rs2);
    assign lt_u = rs1 < rs2;

    assign pc_rel  = op_i.pc + op_i.imm;
    assign reg_rel = rs1 + op_i.imm;
    assign link    = op_i.pc + XLEN'(LINK_OFFSET);

    always_comb begin
        ctrl_o = 1'b1;
        take   = 1'b0;
        data_o = '0;
        case (op_i.opcode)
            op_beq:  take = eq;
            op_bne:  take = !eq;
            op_blt:  take = lt_s;
            op_bge:  take = !lt_s;
            op_bltu: take = lt_u;
            op_bgeu: take = !lt_u;
            op_jal, op_jalr: begin
                take   = 1'b1;
                data_o = link;
            end
            default: ctrl_o = 1'b0;
        endcase
        // branches report the condition itself.
        if (ctrl_o && op_i.opcode != op_jal && op_i.opcode != op_jalr) begin
            data_o = {{(XLEN-1){1'b0}}, take};
        end
    end

    assign redirect_o = take;

    // jalr drops bit 0 of the sum.
    always_comb begin
        if (!take) begin
            target_o = '0;
        end else if (op_i.opcode == op_jalr) begin
            target_o = {reg_rel[XLEN-1:1], 1'b0};
        end else begin
            target_o = pc_rel;
        end
    end

endmodule

// File: hdl/ex_stage.sv
`timescale 1ns/1ps

module ex_stage #(
    parameter int OUT_CREDITS = 2
) (
    input  logic              i_clk,
    input  logic              reset_i,
    input  logic              empty_i,
    input  ex_pkg::ex_op_t    op_i,
    input  logic              credit_i,
    output logic              pop_o,
    output logic              res_valid_o,
    output ex_pkg::ex_res_t   res_o
);
    import ex_pkg::*;

    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;
    logic             credit_ok;
    logic [XLEN-1:0]  alu_data;
    logic             br_ctrl;
    logic             br_redirect;
    logic [XLEN-1:0]  br_data;
    logic [XLEN-1:0]  br_target;
    ex_res_t          res_d;
    ex_res_t          res_q;
    logic             res_valid_q;

    ex_alu u_alu (
        .op_i   (op_i),
        .data_o (alu_data)
    );

    ex_branch u_branch (
        .op_i       (op_i),
        .ctrl_o     (br_ctrl),
        .redirect_o (br_redirect),
        .data_o     (br_data),
        .target_o   (br_target)
    );

    // a credit returning this cycle can be spent at once.
    assign credit_ok = (credit_cnt != '0) || credit_i;
    assign pop_o     = !empty_i && credit_ok;

    // one downstream credit spent per result.
    always_ff @(posedge i_clk) begin
        if (reset_i) begin
            credit_cnt <= CNT_W'(OUT_CREDITS);
        end else begin
            case ({pop_o, credit_i})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_comb begin
        res_d.rd = op_i.rd;
        if (br_ctrl) begin
            res_d.data     = br_data;
            res_d.redirect = br_redirect;
            res_d.target   = br_target;
        end else begin
            res_d.data     = alu_data;
            res_d.redirect = 1'b0;
            res_d.target   = '0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (reset_i) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= pop_o;   // high the cycle after the pop.
        end
    end

    // result payload only moves on a pop.
    always_ff @(posedge i_clk) begin
        if (pop_o) begin
            res_q <= res_d;
        end
    end

    assign res_valid_o = res_valid_q;
    assign res_o       = res_q;

endmodule

// File: hdl/ex_top.sv
`timescale 1ns/1ps

module ex_top #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic              i_clk,
    input  logic              reset_i,
    input  logic              op_valid_i,
    input  ex_pkg::ex_op_t    op_i,
    input  logic              credit_i,
    output logic              in_credit_o,
    output logic              res_valid_o,
    output ex_pkg::ex_res_t   res_o
);
    import ex_pkg::*;

    ex_op_t q_head;
    logic   q_empty;
    logic   stage_pop;

    // upstream holds IN_DEPTH credits, so the queue never overflows.
    credit_fifo #(
        .DEPTH     (IN_DEPTH),
        .payload_t (ex_op_t)
    ) u_op_queue (
        .i_clk   (i_clk),
        .reset_i (reset_i),
        .push_i  (op_valid_i),
        .data_i  (op_i),
        .pop_i   (stage_pop),
        .data_o  (q_head),
        .empty_o (q_empty)
    );

    ex_stage #(
        .OUT_CREDITS (OUT_CREDITS)
    ) u_stage (
        .i_clk       (i_clk),
        .reset_i     (reset_i),
        .empty_i     (q_empty),
        .op_i        (q_head),
        .credit_i    (credit_i),
        .pop_o       (stage_pop),
        .res_valid_o (res_valid_o),
        .res_o       (res_o)
    );

    // every entry leaving the queue frees one upstream credit.
    assign in_credit_o = stage_pop;

endmodule

// File: dv/ex_model.svh
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

// reference result for one operation.
function automatic ex_res_t expected_result(input ex_op_t op);
    ex_res_t                r;
    logic [XLEN-1:0]        b;
    logic signed [XLEN-1:0] s1;
    logic signed [XLEN-1:0] s2;
    logic signed [XLEN-1:0] sb;
    logic [SHAMT_W-1:0]     sh;
    logic                   cond;
    r    = '0;
    r.rd = op.rd;
    b    = op.use_imm ? op.imm : op.rs2_data;
    s1   = op.rs1_data;
    s2   = op.rs2_data;
    sb   = b;
    sh   = b[SHAMT_W-1:0];
    cond = 1'b0;
    case (op.opcode)
        op_add:            r.data = op.rs1_data + b;
        op_sub:            r.data = op.rs1_data - b;
        op_xor:            r.data = op.rs1_data ^ b;
        op_or:             r.data = op.rs1_data | b;
        op_and:            r.data = op.rs1_data & b;
        op_sll:            r.data = op.rs1_data << sh;
        op_srl:            r.data = op.rs1_data >> sh;
        op_sra:            r.data = s1 >>> sh;
        op_slt:            r.data = (s1 < sb) ? 32'd1 : 32'd0;
        op_sltu:           r.data = (op.rs1_data < b) ? 32'd1 : 32'd0;
        op_load, op_store: r.data = op.rs1_data + op.imm;   // always base plus offset.
        op_lui:            r.data = op.imm;
        op_auipc:          r.data = op.pc + op.imm;
        // branches compare the registers, never the immediate.
        op_beq:            cond = (op.rs1_data == op.rs2_data);
        op_bne:            cond = (op.rs1_data != op.rs2_data);
        op_blt:            cond = (s1 < s2);
        op_bge:            cond = (s1 >= s2);
        op_bltu:           cond = (op.rs1_data < op.rs2_data);
        op_bgeu:           cond = (op.rs1_data >= op.rs2_data);
        op_jal, op_jalr: begin
            r.data     = op.pc + XLEN'(LINK_OFFSET);
            r.redirect = 1'b1;
            if (op.opcode == op_jal) begin
                r.target = op.pc + op.imm;
            end else begin
                r.target = (op.rs1_data + op.imm) & ~32'd1;
            end
        end
        default: ;
    endcase
    if (op.opcode inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu}) begin
        r.data     = {{(XLEN-1){1'b0}}, cond};
        r.redirect = cond;
        r.target   = cond ? op.pc + op.imm : 32'd0;
    end
    return r;
endfunction

task automatic check_res(input string name, input ex_res_t exp, input ex_res_t act);
    if (act.rd !== exp.rd) begin
        $display("FAIL %s rd: expected %0d actual %0d", name, exp.rd, act.rd);
        value_errs++;
    end
    if (act.data !== exp.data) begin
        $display("FAIL %s data: expected %h actual %h", name, exp.data, act.data);
        value_errs++;
    end
    if (act.redirect !== exp.redirect) begin
        $display("FAIL %s redirect: expected %b actual %b", name, exp.redirect, act.redirect);
        value_errs++;
    end
    if (act.target !== exp.target) begin
        $display("FAIL %s target: expected %h actual %h", name, exp.target, act.target);
        value_errs++;
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
        $display("FAIL %s: expected %0d actual %0d", name, exp, act);
        value_errs++;
    end
endtask

`endif

// File: dv/ex_tb.sv
`timescale 1ns/1ps

module ex_tb;
    import ex_pkg::*;

    localparam int IN_DEPTH       = 4;
    localparam int OUT_CREDITS    = 2;
    localparam int N_BURST        = 8;
    localparam int N_ALU          = 600;
    localparam int N_CTRL         = 200;
    localparam int N_OTHER        = 100;
    localparam int BP_CYCLES      = 50;
    localparam int TOTAL_OPS      = N_BURST + N_ALU + N_CTRL + N_OTHER + IN_DEPTH + OUT_CREDITS;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_OPS + 200;
    localparam int KIND_ALU       = 0;
    localparam int KIND_CTRL      = 1;
    localparam int KIND_OTHER     = 2;
    localparam int CR_HOLD        = 0;
    localparam int CR_RAND        = 1;
    localparam int CR_ALWAYS      = 2;

    logic    clk;
    logic    reset_i;
    logic    op_valid_i;
    ex_op_t  op_i;
    logic    credit_i;
    logic    in_credit_o;
    logic    res_valid_o;
    ex_res_t res_o;

    logic [31:0] lfsr;
    int          cycle;
    int          value_errs;
    int          proto_errs;
    int          up_credits;   // credits the upstream side still holds.
    int          owed;         // results not yet answered with credit_i.
    int          accepted;
    int          pulses;
    int          results;
    string       test_name;
    ex_res_t     exp_q[$];
    int          res_cycles[$];

    `include "ex_model.svh"

    ex_top #(
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) dut (
        .i_clk       (clk),
        .reset_i     (reset_i),
        .op_valid_i  (op_valid_i),
        .op_i        (op_i),
        .credit_i    (credit_i),
        .in_credit_o (in_credit_o),
        .res_valid_o (res_valid_o),
        .res_o       (res_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    initial begin
        wait (cycle > TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, results still outstanding", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic ex_op_t random_op(input int kind);
        ex_op_t      op;
        logic [31:0] short_imm;
        op.use_imm  = rand_bits(1) != 0;
        op.rd       = REG_ADDR_W'(rand_bits(REG_ADDR_W));
        op.pc       = rand_bits(XLEN) & 32'hffff_fffc;
        op.rs1_data = rand_bits(XLEN);
        op.rs2_data = (rand_bits(2) == 0) ? op.rs1_data : rand_bits(XLEN);   // some equal pairs.
        short_imm   = rand_bits(12);
        op.imm      = (rand_bits(1) != 0) ? {{20{short_imm[11]}}, short_imm[11:0]}
                                          : rand_bits(XLEN);
        case (kind)
            KIND_ALU:  op.opcode = ex_opcode_e'(op_add + 5'(rand_bits(4) % 10));
            KIND_CTRL: op.opcode = ex_opcode_e'(op_beq + 5'(rand_bits(3)));   // beq to jalr.
            default: begin
                case (rand_bits(3) % 5)
                    0:       op.opcode = op_nop;
                    1:       op.opcode = op_load;
                    2:       op.opcode = op_store;
                    3:       op.opcode = op_lui;
                    default: op.opcode = op_auipc;
                endcase
            end
        endcase
        return op;
    endfunction

    // one clock that drives after the edge and samples at the falling edge.
    task automatic run_cycle(input bit want_send, input ex_op_t op, input int credit_mode,
                             output bit sent);
        bit      give;
        ex_res_t exp;
        sent = want_send && (up_credits > 0);
        case (credit_mode)
            CR_RAND:   give = (owed > 0) && (rand_bits(1) != 0);
            CR_ALWAYS: give = (owed > 0);
            default:   give = 1'b0;
        endcase
        @(posedge clk);
        #2;
        op_valid_i = sent;
        if (sent) begin
            op_i = op;
        end else begin
            op_i = '0;
        end
        credit_i = give;
        if (give) begin
            owed--;
        end
        @(negedge clk);
        if (sent) begin
            up_credits--;
            accepted++;
            exp_q.push_back(expected_result(op));
        end
        if (in_credit_o) begin
            up_credits++;
            pulses++;
        end
        if (up_credits < 0 || up_credits > IN_DEPTH) begin
            $display("upstream credit count left its range, now %0d", up_credits);
            proto_errs++;
        end
        if (res_valid_o) begin
            results++;
            owed++;
            res_cycles.push_back(cycle);
            if (owed > OUT_CREDITS) begin
                $display("more results outstanding than downstream credits");
                proto_errs++;
            end
            if (exp_q.size() == 0) begin
                $display("result arrived with no operation outstanding");
                proto_errs++;
            end else begin
                exp = exp_q.pop_front();
                check_res(test_name, exp, res_o);
            end
        end
    endtask

    task automatic drain(input int credit_mode);
        bit sent;
        while (exp_q.size() != 0 || owed != 0) begin
            run_cycle(1'b0, '0, credit_mode, sent);
        end
    endtask

    task automatic run_random(input string name, input int n_ops, input int kind);
        int     n;
        bit     sent;
        ex_op_t op;
        test_name = name;
        n = 0;
        while (n < n_ops) begin
            op = random_op(kind);
            run_cycle(rand_bits(2) != 0, op, CR_RAND, sent);
            if (sent) begin
                n++;
            end
        end
        drain(CR_RAND);
    endtask

    initial begin
        bit     sent;
        int     n;
        int     first_send;
        int     snap_res;
        int     snap_acc;
        int     snap_pulses;
        ex_op_t op;
        lfsr       = 32'd92;
        reset_i    = 1'b1;
        op_valid_i = 1'b0;
        op_i       = '0;
        credit_i   = 1'b0;
        up_credits = IN_DEPTH;
        repeat (3) @(posedge clk);
        #2;
        reset_i = 1'b0;

        test_name = "reset";
        repeat (5) begin
            run_cycle(1'b0, '0, CR_HOLD, sent);
            if (res_valid_o || in_credit_o) begin
                $display("output pulse after reset before any operation was sent");
                proto_errs++;
            end
        end

        // back to back with credit returned as soon as possible.
        test_name  = "burst";
        res_cycles.delete();
        first_send = 0;
        n          = 0;
        while (n < N_BURST) begin
            op = random_op(KIND_ALU);
            run_cycle(1'b1, op, CR_ALWAYS, sent);
            if (sent) begin
                if (n == 0) begin
                    first_send = cycle;
                end
                n++;
            end
        end
        drain(CR_ALWAYS);
        if (res_cycles.size() == N_BURST) begin
            check_count("burst_latency", 2, res_cycles[0] - first_send);
            check_count("burst_spacing", N_BURST - 1, res_cycles[N_BURST-1] - res_cycles[0]);
        end else begin
            check_count("burst_results", N_BURST, res_cycles.size());
        end

        run_random("alu", N_ALU, KIND_ALU);
        run_random("control", N_CTRL, KIND_CTRL);
        run_random("other", N_OTHER, KIND_OTHER);

        test_name   = "backpressure";
        snap_res    = results;
        snap_acc    = accepted;
        snap_pulses = pulses;
        repeat (BP_CYCLES) begin
            op = random_op(KIND_ALU);
            run_cycle(1'b1, op, CR_HOLD, sent);
        end
        check_count("bp_results", OUT_CREDITS, results - snap_res);
        check_count("bp_pulses", OUT_CREDITS, pulses - snap_pulses);
        check_count("bp_queued", IN_DEPTH, (accepted - snap_acc) - (pulses - snap_pulses));
        check_count("bp_up_credits", 0, up_credits);
        drain(CR_RAND);
        check_count("total_results", accepted, results);

        $display("errors: %0d value, %0d protocol, %0d results checked",
                 value_errs, proto_errs, results);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: ex_top.f
+incdir+dv
hdl/ex_pkg.sv
hdl/credit_fifo.sv
hdl/ex_alu.sv
hdl/ex_branch.sv
hdl/ex_stage.sv
hdl/ex_top.sv
dv/ex_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ex_top testbench with Verilator, then scan the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/1ps -f ex_top.f --top-module ex_tb \
    -o ex_tb_sim > build.log 2>&1 &&
    ./obj_dir/ex_tb_sim > sim.log 2>&1 ||
    { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" ||
    { echo "no result line found in sim.log"; exit 1; }
